//--- egress_serializer.sv
`timescale 1ns/1ps
`include "preamble_switch_params.svh"

module egress_serializer
  import preamble_switch_pkg::*;
(
  input  logic      core_clock,
  input  logic      clk1p,
  input  header_t   header,
  input  logic      header_valid,
  output port_vec_t dout,
  output logic      egress_busy
);

  localparam int CNT_BITS = $clog2(`HDR_BITS + 1);

  logic [`HDR_BITS-1:0] hdr_bits;
  logic [`HDR_BITS-1:0] shift_q;
  logic [CNT_BITS-1:0]  bit_cnt;
  addr_t                p_off;
  addr_t                n_off;
  port_idx_t            target;
  logic                 mapped;
  logic                 load;
  logic                 busy_q;
  port_vec_t            lane_sel;
  port_vec_t            lane_q;

  assign hdr_bits = header;

  // Address map decode.
  always_comb
  begin
    p_off  = header.dest_addr - `ADDR_P_BASE;
    n_off  = header.dest_addr - `ADDR_N_BASE;
    target = '0;
    mapped = 1'b0;
    if (p_off < addr_t'(`NUM_P_PORTS))
    begin
      target = port_idx_t'(p_off);
      mapped = 1'b1;
    end
    else if (n_off < addr_t'(`NUM_N_PORTS))
    begin
      target = port_idx_t'(n_off) + port_idx_t'(`NUM_P_PORTS);
      mapped = 1'b1;
    end
  end

  assign lane_sel    = mapped ? (port_vec_t'(1) << target) : '0;
  assign load        = header_valid & mapped & ~busy_q;
  assign egress_busy = busy_q | (header_valid & mapped); // Blocks a grant on the same edge.

  always_ff @(posedge core_clock)
  begin
    if (load)
    begin
      shift_q <= hdr_bits << 1; // MSB leaves on the load edge.
    end
    else if (busy_q)
    begin
      shift_q <= shift_q << 1;
    end
  end

  always_ff @(posedge core_clock or posedge clk1p)
  begin
    if (clk1p)
    begin
      busy_q  <= 1'b0;
      lane_q  <= '0;
      bit_cnt <= '0;
      dout    <= '0;
    end
    else if (load)
    begin
      busy_q  <= 1'b1;
      lane_q  <= lane_sel;
      bit_cnt <= CNT_BITS'(1);
      dout    <= lane_sel & {`NUM_PORTS{hdr_bits[`HDR_BITS-1]}};
    end
    else if (busy_q)
    begin
      if (bit_cnt == CNT_BITS'(`HDR_BITS))
      begin
        busy_q  <= 1'b0;
        bit_cnt <= '0;
        dout    <= '0; // Idle lines rest low.
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
        dout    <= lane_q & {`NUM_PORTS{shift_q[`HDR_BITS-1]}};
      end
    end
  end

endmodule

//--- header_deserializer.sv
`timescale 1ns/1ps
`include "preamble_switch_params.svh"

module header_deserializer
  import preamble_switch_pkg::*;
(
  input  logic      core_clock,
  input  logic      clk1p,
  input  port_vec_t din,
  input  logic      grant_active,
  input  port_idx_t grant_idx,
  output header_t   header,
  output logic      header_valid
);

  localparam int CNT_BITS = $clog2(`HDR_BITS + 1);

  logic                 line_bit;
  logic                 shifting;  // Line sampled after the turnaround.
  logic                 captured;  // This grant's header already delivered.
  logic                 sample_en;
  logic                 last_done;
  logic [CNT_BITS-1:0]  bit_cnt;
  logic [`HDR_BITS-1:0] shift_q;

  assign line_bit  = din[grant_idx]; // Granted ingress line.
  assign last_done = (bit_cnt == CNT_BITS'(`HDR_BITS));
  assign sample_en = grant_active & shifting & ~last_done;

  always_ff @(posedge core_clock)
  begin
    if (sample_en)
    begin
      shift_q <= {shift_q[`HDR_BITS-2:0], line_bit};
    end
  end

  always_ff @(posedge core_clock or posedge clk1p)
  begin
    if (clk1p)
    begin
      shifting     <= 1'b0;
      captured     <= 1'b0;
      bit_cnt      <= '0;
      header       <= '0;
      header_valid <= 1'b0;
    end
    else
    begin
      header_valid <= 1'b0;
      if (!grant_active)
      begin
        shifting <= 1'b0;
        captured <= 1'b0;
        bit_cnt  <= '0;
      end
      else if (!shifting && !captured)
      begin
        shifting <= 1'b1; // First edge with grant seen is the turnaround.
      end
      else if (shifting)
      begin
        if (last_done)
        begin
          header       <= header_t'(shift_q);
          header_valid <= 1'b1;
          shifting     <= 1'b0;
          captured     <= 1'b1;
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- port_arbiter.sv
`timescale 1ns/1ps
`include "preamble_switch_params.svh"

module port_arbiter
  import preamble_switch_pkg::*;
(
  input  logic      core_clock,
  input  logic      clk1p,
  input  port_vec_t req,
  input  logic      egress_busy,
  output port_vec_t gnt,
  output logic      grant_active,
  output port_idx_t grant_idx
);

  port_idx_t pick_idx;
  logic      any_req;

  // Lowest requesting index wins.
  always_comb
  begin
    pick_idx = '0;
    any_req  = |req;
    for (int i = `NUM_PORTS - 1; i >= 0; i--)
    begin
      if (req[i])
      begin
        pick_idx = port_idx_t'(i);
      end
    end
  end

  always_ff @(posedge core_clock or posedge clk1p)
  begin
    if (clk1p)
    begin
      gnt          <= '0;
      grant_active <= 1'b0;
      grant_idx    <= '0;
    end
    else if (grant_active)
    begin
      // Hold until the owner lets go of req.
      if (!req[grant_idx])
      begin
        gnt          <= '0;
        grant_active <= 1'b0;
      end
    end
    else if (any_req && !egress_busy) // No new grant while egress is still sending.
    begin
      gnt          <= port_vec_t'(1) << pick_idx;
      grant_active <= 1'b1;
      grant_idx    <= pick_idx;
    end
  end

endmodule

//--- preamble_switch.f
+incdir+.
preamble_switch_pkg.sv
port_arbiter.sv
header_deserializer.sv
egress_serializer.sv
preamble_switch.sv
tb_preamble_switch.sv

//--- preamble_switch.sv
`timescale 1ns/1ps

module preamble_switch
  import preamble_switch_pkg::*;
(
  input  logic      core_clock,
  input  logic      clk1p,
  input  port_vec_t req,
  input  port_vec_t din,
  output port_vec_t gnt,
  output port_vec_t dout,
  output logic      header_valid,
  output addr_t     preamble,
  output addr_t     src_addr,
  output addr_t     dest_addr,
  output addr_t     clock_freq,
  output wide_t     data_length,
  output wide_t     data_size,
  output wide_t     data_crc
);

  logic      grant_active;
  port_idx_t grant_idx;
  logic      egress_busy;
  header_t   header;

  port_arbiter u_arbiter (
    .core_clock   (core_clock),
    .clk1p        (clk1p),
    .req          (req),
    .egress_busy  (egress_busy),
    .gnt          (gnt),
    .grant_active (grant_active),
    .grant_idx    (grant_idx)
  );

  header_deserializer u_deserializer (
    .core_clock   (core_clock),
    .clk1p        (clk1p),
    .din          (din),
    .grant_active (grant_active),
    .grant_idx    (grant_idx),
    .header       (header),
    .header_valid (header_valid)
  );

  egress_serializer u_serializer (
    .core_clock   (core_clock),
    .clk1p        (clk1p),
    .header       (header),
    .header_valid (header_valid),
    .dout         (dout),
    .egress_busy  (egress_busy)
  );

  // Captured fields hold until the next header.
  assign preamble    = header.preamble;
  assign src_addr    = header.src_addr;
  assign dest_addr   = header.dest_addr;
  assign clock_freq  = header.clock_freq;
  assign data_length = header.data_length;
  assign data_size   = header.data_size;
  assign data_crc    = header.data_crc;

endmodule

//--- preamble_switch_params.svh
`ifndef PREAMBLE_SWITCH_PARAMS_SVH
`define PREAMBLE_SWITCH_PARAMS_SVH

// Port map. Index 0..4 are ports 1p..5p, index 5..8 are ports 1n..4n.
`define NUM_PORTS   9
`define NUM_P_PORTS 5
`define NUM_N_PORTS 4

// Header layout, sent MSB first.
`define HDR_BITS  80
`define ADDR_BITS 8
`define WIDE_BITS 16 // Length, size and CRC fields.

// Destination address map.
`define ADDR_P_BASE 8'hF0 // 0xF0..0xF4 go to 1p..5p.
`define ADDR_N_BASE 8'h00 // 0x00..0x03 go to 1n..4n.

`endif

//--- preamble_switch_pkg.sv
`include "preamble_switch_params.svh"

package preamble_switch_pkg;

  // One bit per serial port.
  typedef logic [`NUM_PORTS-1:0] port_vec_t;

  typedef logic [$clog2(`NUM_PORTS)-1:0] port_idx_t;

  // Address and other byte wide header fields.
  typedef logic [`ADDR_BITS-1:0] addr_t;

  typedef logic [`WIDE_BITS-1:0] wide_t;

  // Full header with the first field in the top bits.
  typedef struct packed {
    addr_t preamble;
    addr_t src_addr;
    addr_t dest_addr;
    addr_t clock_freq;
    wide_t data_length;
    wide_t data_size;
    wide_t data_crc;
  } header_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_preamble_switch \
  -f preamble_switch.f \
  -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

//--- tb_switch_model.svh
localparam int VALID_EDGE = `HDR_BITS + 2;         // Grant edge to header_valid.
localparam int DOUT_EDGE  = `HDR_BITS + 3;         // Grant edge to the first egress bit.
localparam int BUSY_LAST  = DOUT_EDGE + `HDR_BITS; // Last edge that refuses a grant.

port_vec_t exp_gnt       = '0;
port_vec_t exp_dout      = '0;
logic      exp_hv        = 1'b0;
header_t   held_hdr      = '0; // Fields expected on the outputs.
header_t   rec_hdr       = '0;
logic      rec_valid     = 1'b0;
int        rec_edge      = 0;
int        rec_target    = -1;
int        owner_idx     = 0;
int        hdrs_captured = 0;
int        mapped_seen   = 0;
int        unmapped_seen = 0;

// 0xF0..0xF4 go to 1p..5p and 0x00..0x03 go to 1n..4n. Anything else is dropped.
function automatic int map_dest(input addr_t a);
  int v;
  int p_base;
  int n_base;
  v      = int'(a);
  p_base = int'(`ADDR_P_BASE);
  n_base = int'(`ADDR_N_BASE);
  if (v >= p_base && v < p_base + `NUM_P_PORTS)
  begin
    return v - p_base;
  end
  if (v >= n_base && v < n_base + `NUM_N_PORTS)
  begin
    return v - n_base + `NUM_P_PORTS;
  end
  return -1;
endfunction

function automatic int lowest_index(input port_vec_t r);
  for (int i = 0; i < `NUM_PORTS; i++)
  begin
    if (r[i])
    begin
      return i;
    end
  end
  return -1;
endfunction

function automatic logic egress_blocks(input int c);
  return rec_valid && rec_target >= 0 && c >= rec_edge + DOUT_EDGE && c <= rec_edge + BUSY_LAST;
endfunction

function automatic logic model_idle(input int c);
  return exp_gnt == '0 && (!rec_valid || c > rec_edge + BUSY_LAST + 1);
endfunction

// Works out the outputs expected after edge c from req as seen at that edge.
task automatic model_step(input int c, input port_vec_t s_req);
  int k;
  if (exp_gnt != '0)
  begin
    if (!s_req[owner_idx])
    begin
      exp_gnt = '0; // Owner let go.
    end
  end
  else if (s_req != '0 && !egress_blocks(c))
  begin
    owner_idx          = lowest_index(s_req);
    exp_gnt            = '0;
    exp_gnt[owner_idx] = 1'b1;
    rec_valid          = 1'b1;
    rec_edge           = c;
    rec_hdr            = sent_hdr[owner_idx];
    rec_target         = map_dest(rec_hdr.dest_addr);
  end
  exp_hv = rec_valid && (c == rec_edge + VALID_EDGE);
  if (exp_hv)
  begin
    held_hdr = rec_hdr;
    if (rec_target >= 0)
    begin
      mapped_seen = mapped_seen + 1;
    end
    else
    begin
      unmapped_seen = unmapped_seen + 1;
    end
  end
  exp_dout = '0;
  k        = c - rec_edge - DOUT_EDGE;
  if (rec_valid && rec_target >= 0 && k >= 0 && k < `HDR_BITS)
  begin
    exp_dout[rec_target] = rec_hdr[`HDR_BITS - 1 - k]; // MSB first.
  end
endtask

task automatic report_mismatch(input string name, input logic [15:0] exp, input logic [15:0] act);
  report_error($sformatf("mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
                         $time, name, exp, act));
endtask

task automatic check_field(input string name, input logic [15:0] exp, input logic [15:0] act);
  assert (exp == act) else report_mismatch(name, exp, act);
endtask

task automatic check_outputs(input port_vec_t s_gnt, input port_vec_t s_dout,
                             input logic s_hv, input header_t s_hdr);
  assert ($onehot0(s_gnt))
    else report_error($sformatf("More than one grant is high at %0t ns.", $time));
  assert (s_gnt == exp_gnt) else report_mismatch("gnt", 16'(exp_gnt), 16'(s_gnt));
  assert (s_dout == exp_dout) else report_mismatch("dout", 16'(exp_dout), 16'(s_dout));
  assert (s_hv == exp_hv) else report_mismatch("header_valid", 16'(exp_hv), 16'(s_hv));
  check_field("preamble", 16'(held_hdr.preamble), 16'(s_hdr.preamble));
  check_field("src_addr", 16'(held_hdr.src_addr), 16'(s_hdr.src_addr));
  check_field("dest_addr", 16'(held_hdr.dest_addr), 16'(s_hdr.dest_addr));
  check_field("clock_freq", 16'(held_hdr.clock_freq), 16'(s_hdr.clock_freq));
  check_field("data_length", held_hdr.data_length, s_hdr.data_length);
  check_field("data_size", held_hdr.data_size, s_hdr.data_size);
  check_field("data_crc", held_hdr.data_crc, s_hdr.data_crc);
  if (s_hv)
  begin
    hdrs_captured = hdrs_captured + 1; // Pulses seen on the DUT.
  end
endtask

//--- tb_preamble_switch.sv
`timescale 1ns/1ps
`include "preamble_switch_params.svh"

module tb_preamble_switch
  import preamble_switch_pkg::*;
();

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 16;
  localparam int HDRS_PER_PORT  = 4;
  localparam int TOTAL_HDRS     = `NUM_PORTS * HDRS_PER_PORT;
  localparam int CYCLES_PER_HDR = 200;
  localparam int SEED           = 30056;

  // Sender phases.
  localparam int PH_WAIT    = 0;
  localparam int PH_SEND    = 1;
  localparam int PH_RELEASE = 2;
  localparam int PH_DONE    = 3;

  logic      core_clock;
  logic      clk1p;
  port_vec_t req;
  port_vec_t din;
  port_vec_t gnt;
  port_vec_t dout;
  logic      header_valid;
  addr_t     preamble;
  addr_t     src_addr;
  addr_t     dest_addr;
  addr_t     clock_freq;
  wide_t     data_length;
  wide_t     data_size;
  wide_t     data_crc;
  header_t   seen_hdr;

  logic [31:0] lcg_state;
  logic        senders_on;
  int          edge_cnt;
  header_t     sent_hdr [`NUM_PORTS]; // Header each port is sending now.
  int          phase [`NUM_PORTS];
  int          wait_left [`NUM_PORTS];
  int          bits_sent [`NUM_PORTS];
  int          hdrs_left [`NUM_PORTS];

  preamble_switch dut_i (
    .core_clock   (core_clock),
    .clk1p        (clk1p),
    .req          (req),
    .din          (din),
    .gnt          (gnt),
    .dout         (dout),
    .header_valid (header_valid),
    .preamble     (preamble),
    .src_addr     (src_addr),
    .dest_addr    (dest_addr),
    .clock_freq   (clock_freq),
    .data_length  (data_length),
    .data_size    (data_size),
    .data_crc     (data_crc)
  );

  assign seen_hdr = {preamble, src_addr, dest_addr, clock_freq, data_length, data_size, data_crc};

  always #(CLK_PERIOD / 2) core_clock = ~core_clock;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand()) % n;
  endfunction

  // About 70% of destinations hit the address map.
  function automatic header_t make_header();
    header_t h;
    int      j;
    h.preamble   = addr_t'(next_rand());
    h.src_addr   = addr_t'(next_rand());
    h.clock_freq = addr_t'(next_rand());
    if (rand_below(10) < 7)
    begin
      j = rand_below(`NUM_PORTS);
      if (j < `NUM_P_PORTS)
      begin
        h.dest_addr = addr_t'(int'(`ADDR_P_BASE) + j);
      end
      else
      begin
        h.dest_addr = addr_t'(int'(`ADDR_N_BASE) + j - `NUM_P_PORTS);
      end
    end
    else
    begin
      h.dest_addr = addr_t'(`NUM_N_PORTS + rand_below(int'(`ADDR_P_BASE) - `NUM_N_PORTS));
    end
    h.data_length = next_rand();
    h.data_size   = next_rand();
    h.data_crc    = next_rand();
    return h;
  endfunction

  function automatic logic senders_finished();
    logic all_done;
    all_done = 1'b1;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (phase[p] != PH_DONE)
      begin
        all_done = 1'b0;
      end
    end
    return all_done;
  endfunction

  `include "tb_switch_model.svh"

  // Ports are stepped in a fixed order so the random sequence repeats.
  always @(posedge core_clock)
  begin
    if (senders_on)
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        case (phase[p])
          PH_WAIT:
          begin
            if (wait_left[p] > 0)
            begin
              wait_left[p] = wait_left[p] - 1;
            end
            else if (hdrs_left[p] == 0)
            begin
              phase[p] = PH_DONE;
            end
            else
            begin
              sent_hdr[p] <= make_header();
              req[p]      <= 1'b1;
              bits_sent[p] = 0;
              phase[p]     = PH_SEND;
            end
          end
          PH_SEND:
          begin
            if (gnt[p] && bits_sent[p] < `HDR_BITS)
            begin
              din[p]      <= sent_hdr[p][`HDR_BITS - 1 - bits_sent[p]];
              bits_sent[p] = bits_sent[p] + 1;
            end
            else if (gnt[p])
            begin
              req[p]  <= 1'b0; // All 80 bits sent.
              din[p]  <= 1'b0;
              phase[p] = PH_RELEASE;
            end
          end
          PH_RELEASE:
          begin
            if (!gnt[p])
            begin
              hdrs_left[p] = hdrs_left[p] - 1;
              wait_left[p] = rand_below(32);
              phase[p]     = PH_WAIT;
            end
          end
          default:
          begin
          end
        endcase
      end
    end
  end

  always @(posedge core_clock)
  begin
    edge_cnt = edge_cnt + 1;
    if (!clk1p)
    begin
      check_outputs(gnt, dout, header_valid, seen_hdr);
      model_step(edge_cnt, req);
    end
  end

  initial
  begin
    core_clock = 1'b0;
    clk1p      = 1'b1;
    req        = '0;
    din        = '0;
    senders_on = 1'b0;
    edge_cnt   = 0;
    lcg_state  = SEED;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      phase[p]     = PH_WAIT;
      hdrs_left[p] = HDRS_PER_PORT;
      bits_sent[p] = 0;
      wait_left[p] = rand_below(8); // Short first waits so requests collide.
      sent_hdr[p]  = '0;
    end
    repeat (RESET_CYCLES) @(posedge core_clock);
    clk1p      <= 1'b0;
    senders_on <= 1'b1;
    @(negedge core_clock);
    while (!senders_finished() || !model_idle(edge_cnt))
    begin
      @(negedge core_clock);
    end
    assert (hdrs_captured == TOTAL_HDRS)
      else report_error($sformatf("Only %0d of %0d headers were captured.",
                                  hdrs_captured, TOTAL_HDRS));
    assert (mapped_seen > 0 && unmapped_seen > 0)
      else report_error("The run did not cover both mapped and unmapped destinations.");
    $display("Simulation finished: PASS");
    $finish;
  end

  initial
  begin
    #(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_HDR * TOTAL_HDRS));
    report_error("Timeout: the headers were not all sent and forwarded in time.");
  end

endmodule
